// ==== verilog/sifhCfgPkg.sv ====
package sifhCfgPkg;

    // pixel number width, 4 pixels
    localparam int pixelBits = 2;

    // time bin width, 16 bins per pixel
    localparam int binBits = 4;

    // bin count width, saturates at all ones
    localparam int countBits = 8;

    // histogram RAM address, pixel in the upper bits
    localparam int addrBits = pixelBits + binBits;

    // pixel index
    typedef logic [pixelBits-1:0] pixelT;

    // time bin index
    typedef logic [binBits-1:0] binT;

    // saturating photon count
    typedef logic [countBits-1:0] countT;

    // {pixel, bin}
    typedef logic [addrBits-1:0] addrT;

endpackage

// ==== verilog/sifhBusPkg.sv ====
package sifhBusPkg;

    // one timestamped photon
    typedef struct packed {
        sifhCfgPkg::pixelT pixel;
        sifhCfgPkg::binT   bin;
    } eventT;

    // one access to the histogram RAM
    typedef struct packed {
        // request present
        logic               valid;
        // 1 = write wdata, 0 = read
        logic               write;
        sifhCfgPkg::addrT   addr;
        // unused on reads
        sifhCfgPkg::countT  wdata;
    } memReqT;

    // peak of one pixel's histogram
    typedef struct packed {
        sifhCfgPkg::pixelT pixel;
        // lowest bin holding the maximum
        sifhCfgPkg::binT   bin;
        sifhCfgPkg::countT count;
    } peakT;

endpackage

// ==== verilog/eventQueue.sv ====
`timescale 1ns/100ps

module eventQueue #(
    parameter int queueDepth = 4
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              eventValid,
    input  sifhBusPkg::eventT eventIn,
    input  logic              queuePop,
    output logic              queueValid,
    output sifhBusPkg::eventT queueHead,
    output logic              eventCredit
);

    localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int occBits = $clog2(queueDepth + 1);

    // event storage
    sifhBusPkg::eventT mem [queueDepth];

    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [occBits-1:0] occupancy;
    logic               push;
    logic               pop;

    // upstream only sends while holding a credit, so never full here
    assign push = eventValid;
    assign pop  = queuePop && queueValid;

    assign queueValid = (occupancy != '0);
    assign queueHead  = mem[rdPtr];

    // every released entry hands one credit back upstream
    assign eventCredit = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= eventIn;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
        end else begin
            // pointers wrap at depth, which need not be a power of two
            if (push) begin
                wrPtr <= (wrPtr == ptrBits'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrBits'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

// ==== verilog/histBuilder.sv ====
`timescale 1ns/100ps

module histBuilder (
    input  logic               clk,
    input  logic               arstN,
    input  logic               queueValid,
    input  sifhBusPkg::eventT  queueHead,
    input  logic               scanBusy,
    input  logic               memGrant,
    input  sifhCfgPkg::countT  memRdata,
    output logic               queuePop,
    output logic               builderIdle,
    output sifhBusPkg::memReqT memReq
);

    typedef enum logic [1:0] {
        sIdle,
        sRead,
        sWait,
        sWrite
    } stateT;

    stateT             state;
    stateT             nextState;
    sifhCfgPkg::addrT  headAddr;
    sifhCfgPkg::addrT  addrReg;
    sifhCfgPkg::countT wdataReg;
    logic              startOk;

    // pixel selects the 16-word block, bin the word inside it
    assign headAddr = {queueHead.pixel, queueHead.bin};

    // no new event while the scanner owns the histograms
    assign startOk = queueValid && !scanBusy;

    // scanner drain waits on this
    assign builderIdle = (state == sIdle);

    always_comb begin
        memReq    = '0;
        queuePop  = 1'b0;
        nextState = state;
        case (state)
            sIdle: begin
                if (startOk) begin
                    memReq.valid = 1'b1;
                    memReq.addr  = headAddr;
                    // head leaves the queue only once its read is granted
                    queuePop     = memGrant;
                    nextState    = memGrant ? sWait : sRead;
                end
            end
            sRead: begin
                // lost to the scanner, retry the same head
                memReq.valid = 1'b1;
                memReq.addr  = headAddr;
                queuePop     = memGrant;
                if (memGrant) begin
                    nextState = sWait;
                end
            end
            sWait: begin
                // read data on memRdata this cycle
                nextState = sWrite;
            end
            sWrite: begin
                memReq.valid = 1'b1;
                memReq.write = 1'b1;
                memReq.addr  = addrReg;
                memReq.wdata = wdataReg;
                if (memGrant) begin
                    nextState = sIdle;
                end
            end
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    // payload of the event in flight
    always_ff @(posedge clk) begin
        if (queuePop) begin
            addrReg <= headAddr;
        end
        if (state == sWait) begin
            // increment, holding at full scale
            wdataReg <= (memRdata == '1) ? memRdata : memRdata + 1'b1;
        end
    end

endmodule

// ==== verilog/peakScanner.sv ====
`timescale 1ns/100ps

module peakScanner #(
    parameter int peakCredits = 2
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               acqDone,
    input  logic               builderIdle,
    input  logic               memGrant,
    input  sifhCfgPkg::countT  memRdata,
    input  logic               peakCreditIn,
    output logic               scanBusy,
    output sifhBusPkg::memReqT memReq,
    output logic               peakValid,
    output sifhBusPkg::peakT   peakOut
);

    localparam int credBits = $clog2(peakCredits + 1);

    typedef enum logic [2:0] {
        sIdle,
        sDrain,
        sRead,
        sClear,
        sEmit,
        sDone
    } stateT;

    stateT              state;
    sifhCfgPkg::pixelT  pixelCnt;
    sifhCfgPkg::binT    binCnt;
    sifhCfgPkg::binT    maxBin;
    sifhCfgPkg::countT  maxCount;
    logic [credBits-1:0] credits;
    // read granted, data due this cycle
    logic               rdPending;

    assign scanBusy = (state != sIdle);

    // one peak per cycle at most, only against a held credit
    assign peakValid = (state == sEmit) && (credits != '0);

    assign peakOut.pixel = pixelCnt;
    assign peakOut.bin   = maxBin;
    assign peakOut.count = maxCount;

    always_comb begin
        memReq = '0;
        memReq.addr = {pixelCnt, binCnt};
        case (state)
            sRead: begin
                memReq.valid = !rdPending;
            end
            sClear: begin
                // zero the bin just read, ready for the next acquisition
                memReq.valid = 1'b1;
                memReq.write = 1'b1;
            end
            default: memReq.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits <= credBits'(peakCredits);
        end else begin
            case ({peakCreditIn, peakValid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= sIdle;
            pixelCnt  <= '0;
            binCnt    <= '0;
            maxBin    <= '0;
            maxCount  <= '0;
            rdPending <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (acqDone) begin
                        state <= sDrain;
                    end
                end
                sDrain: begin
                    // let the builder finish its read-modify-write first
                    if (builderIdle) begin
                        state    <= sRead;
                        pixelCnt <= '0;
                        binCnt   <= '0;
                        maxBin   <= '0;
                        maxCount <= '0;
                    end
                end
                sRead: begin
                    if (rdPending) begin
                        rdPending <= 1'b0;
                        state     <= sClear;
                        // strictly greater, so ties keep the lower bin
                        if (memRdata > maxCount) begin
                            maxCount <= memRdata;
                            maxBin   <= binCnt;
                        end
                    end else if (memGrant) begin
                        rdPending <= 1'b1;
                    end
                end
                sClear: begin
                    if (memGrant) begin
                        if (binCnt == '1) begin
                            state <= sEmit;
                        end else begin
                            binCnt <= binCnt + 1'b1;
                            state  <= sRead;
                        end
                    end
                end
                sEmit: begin
                    // no credit, scan holds here before the next pixel
                    if (peakValid) begin
                        if (pixelCnt == '1) begin
                            state <= sDone;
                        end else begin
                            pixelCnt <= pixelCnt + 1'b1;
                            binCnt   <= '0;
                            maxBin   <= '0;
                            maxCount <= '0;
                            state    <= sRead;
                        end
                    end
                end
                sDone: begin
                    // busy drops one cycle after the last peak
                    state <= sIdle;
                end
                default: state <= sIdle;
            endcase
        end
    end

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/100ps

module memArbiter (
    input  logic               clk,
    input  logic               arstN,
    input  sifhBusPkg::memReqT scanReq,
    input  sifhBusPkg::memReqT buildReq,
    input  sifhCfgPkg::countT  ramRdata,
    output logic               scanGrant,
    output logic               buildGrant,
    output sifhBusPkg::memReqT ramReq,
    output sifhCfgPkg::countT  rdata
);

    // read issued last cycle, per peer
    logic rdScan;
    logic rdBuild;

    // fixed priority, scanner first
    assign scanGrant  = scanReq.valid;
    assign buildGrant = buildReq.valid && !scanReq.valid;

    always_comb begin
        if (scanGrant) begin
            ramReq = scanReq;
        end else if (buildGrant) begin
            ramReq = buildReq;
        end else begin
            ramReq = '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdScan  <= 1'b0;
            rdBuild <= 1'b0;
        end else begin
            rdScan  <= scanGrant && !scanReq.write;
            rdBuild <= buildGrant && !buildReq.write;
        end
    end

    // broadcast to both peers, only while a read result is due
    assign rdata = (rdScan || rdBuild) ? ramRdata : '0;

endmodule

// ==== verilog/histRam.sv ====
`timescale 1ns/100ps

module histRam (
    input  logic               clk,
    input  logic               arstN,
    input  sifhBusPkg::memReqT ramReq,
    output sifhCfgPkg::countT  ramRdata
);

    localparam int memWords = 1 << sifhCfgPkg::addrBits;

    // 4 pixels x 16 bins
    sifhCfgPkg::countT mem [memWords];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // histograms start empty
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
            ramRdata <= '0;
        end else if (ramReq.valid) begin
            if (ramReq.write) begin
                mem[ramReq.addr] <= ramReq.wdata;
            end else begin
                // one-cycle read latency
                ramRdata <= mem[ramReq.addr];
            end
        end
    end

endmodule

// ==== verilog/sifhTop.sv ====
`timescale 1ns/100ps

module sifhTop #(
    parameter int queueDepth  = 4,
    parameter int peakCredits = 2
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              eventValid,
    input  sifhBusPkg::eventT eventIn,
    input  logic              acqDone,
    input  logic              peakCreditIn,
    output logic              eventCredit,
    output logic              peakValid,
    output sifhBusPkg::peakT  peakOut,
    output logic              scanBusy
);

    // queue to builder
    logic               queueValid;
    sifhBusPkg::eventT  queueHead;
    logic               queuePop;
    logic               builderIdle;

    // peers to arbiter
    sifhBusPkg::memReqT buildReq;
    sifhBusPkg::memReqT scanReq;
    logic               buildGrant;
    logic               scanGrant;

    // arbiter to RAM and back
    sifhBusPkg::memReqT ramReq;
    sifhCfgPkg::countT  ramRdata;
    sifhCfgPkg::countT  rdata;

    eventQueue #(
        .queueDepth(queueDepth)
    ) eventQueue_inst (
        .clk        (clk),
        .arstN      (arstN),
        .eventValid (eventValid),
        .eventIn    (eventIn),
        .queuePop   (queuePop),
        .queueValid (queueValid),
        .queueHead  (queueHead),
        .eventCredit(eventCredit)
    );

    histBuilder histBuilder_inst (
        .clk        (clk),
        .arstN      (arstN),
        .queueValid (queueValid),
        .queueHead  (queueHead),
        .scanBusy   (scanBusy),
        .memGrant   (buildGrant),
        .memRdata   (rdata),
        .queuePop   (queuePop),
        .builderIdle(builderIdle),
        .memReq     (buildReq)
    );

    peakScanner #(
        .peakCredits(peakCredits)
    ) peakScanner_inst (
        .clk         (clk),
        .arstN       (arstN),
        .acqDone     (acqDone),
        .builderIdle (builderIdle),
        .memGrant    (scanGrant),
        .memRdata    (rdata),
        .peakCreditIn(peakCreditIn),
        .scanBusy    (scanBusy),
        .memReq      (scanReq),
        .peakValid   (peakValid),
        .peakOut     (peakOut)
    );

    memArbiter memArbiter_inst (
        .clk       (clk),
        .arstN     (arstN),
        .scanReq   (scanReq),
        .buildReq  (buildReq),
        .ramRdata  (ramRdata),
        .scanGrant (scanGrant),
        .buildGrant(buildGrant),
        .ramReq    (ramReq),
        .rdata     (rdata)
    );

    histRam histRam_inst (
        .clk     (clk),
        .arstN   (arstN),
        .ramReq  (ramReq),
        .ramRdata(ramRdata)
    );

endmodule

// ==== tests/sifhClkGen.sv ====
`timescale 1ns/100ps

module sifhClkGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== tests/sifhTop_chk.sv ====
`timescale 1ns/100ps

module sifhTopChk #(
    parameter int queueDepth  = 4,
    parameter int peakCredits = 2
) (
    input logic clk,
    input logic arstN,
    input logic scanGrant,
    input logic buildGrant,
    input logic eventValid,
    input logic queueValid,
    input logic queuePop,
    input logic peakValid,
    input logic peakCreditIn
);

    // shadow of the scanner's output credits
    int credCnt;
    // queue fill level from the pushes and the pops the builder really makes
    int occCnt;
    // failed assertions so far
    int failCount = 0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credCnt <= peakCredits;
            occCnt  <= 0;
        end else begin
            credCnt <= credCnt + (peakCreditIn ? 1 : 0) - (peakValid ? 1 : 0);
            occCnt  <= occCnt + (eventValid ? 1 : 0) - ((queuePop && queueValid) ? 1 : 0);
        end
    end

    // single-port RAM, one owner per cycle
    grantExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(scanGrant && buildGrant))
        else begin
            failCount++;
            $error("scanner and builder granted in the same cycle");
        end

    peakNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
        peakValid |-> (credCnt > 0))
        else begin
            failCount++;
            $error("peakValid while the output credit counter is zero");
        end

    queueBounded: assert property (@(posedge clk) disable iff (!arstN)
        occCnt <= queueDepth)
        else begin
            failCount++;
            $error("event queue holds more than its depth");
        end

endmodule

bind sifhTop sifhTopChk #(
    .queueDepth (queueDepth),
    .peakCredits(peakCredits)
) sifhTopChk_inst (
    .clk         (clk),
    .arstN       (arstN),
    .scanGrant   (scanGrant),
    .buildGrant  (buildGrant),
    .eventValid  (eventValid),
    .queueValid  (queueValid),
    .queuePop    (queuePop),
    .peakValid   (peakValid),
    .peakCreditIn(peakCreditIn)
);

// ==== tests/sifhTb.sv ====
`timescale 1ns/100ps

module sifhTb;

    localparam int queueDepth  = 4;
    localparam int peakCredits = 2;
    localparam int numPixels   = 1 << sifhCfgPkg::pixelBits;
    localparam int numBins     = 1 << sifhCfgPkg::binBits;
    localparam int countMax    = (1 << sifhCfgPkg::countBits) - 1;
    localparam int numAcqs     = 4;
    localparam int numRows     = 13;
    // scanned with peakCreditIn held low at first
    localparam int holdAcq     = 3;
    localparam int randEvents  = 16;
    localparam int holdCycles  = 150;
    localparam int creditLimit = 200;
    localparam int drainLimit  = 500;
    localparam int scanLimit   = 2000;

    typedef struct packed {
        logic [1:0]        acq;
        sifhCfgPkg::pixelT pixel;
        sifhCfgPkg::binT   bin;
        logic [15:0]       reps;
    } stimRowT;

    // acq, pixel, bin, repeats
    stimRowT stimTable [numRows] = '{
        '{2'd0, 2'd0, 4'd5, 16'd300},
        '{2'd0, 2'd1, 4'd3, 16'd4},
        '{2'd0, 2'd1, 4'd9, 16'd6},
        '{2'd0, 2'd2, 4'd0, 16'd2},
        '{2'd0, 2'd3, 4'd15, 16'd1},
        '{2'd1, 2'd0, 4'd2, 16'd3},
        '{2'd1, 2'd1, 4'd7, 16'd5},
        '{2'd1, 2'd2, 4'd12, 16'd2},
        // tie, bin 4 wins
        '{2'd2, 2'd0, 4'd11, 16'd4},
        '{2'd2, 2'd0, 4'd4, 16'd4},
        '{2'd2, 2'd2, 4'd6, 16'd3},
        '{2'd3, 2'd3, 4'd8, 16'd2},
        '{2'd3, 2'd1, 4'd1, 16'd1}
    };

    logic              clk;
    logic              arstN;
    logic              eventValid;
    sifhBusPkg::eventT eventIn;
    logic              acqDone;
    logic              peakCreditIn;
    logic              eventCredit;
    logic              peakValid;
    sifhBusPkg::peakT  peakOut;
    logic              scanBusy;

    // reference histograms of the acquisition being filled
    int               refHist [numPixels][numBins];
    sifhBusPkg::peakT expPeaks [numPixels];
    sifhBusPkg::peakT peakQ [$];
    logic [7:0]       lfsr = 8'd57;
    int               sentCnt = 0;
    int               retCnt = 0;
    int               maxOutstanding = 0;
    int               peaksTotal = 0;
    int               creditsGiven = 0;
    int               valueErrors = 0;
    int               protocolErrors = 0;
    int               timeouts = 0;

    sifhClkGen #(
        .periodNs   (8),
        .resetCycles(10)
    ) clkGen_inst (
        .clk  (clk),
        .arstN(arstN)
    );

    sifhTop #(
        .queueDepth (queueDepth),
        .peakCredits(peakCredits)
    ) sifhTop_inst (
        .clk         (clk),
        .arstN       (arstN),
        .eventValid  (eventValid),
        .eventIn     (eventIn),
        .acqDone     (acqDone),
        .peakCreditIn(peakCreditIn),
        .eventCredit (eventCredit),
        .peakValid   (peakValid),
        .peakOut     (peakOut),
        .scanBusy    (scanBusy)
    );

    // x^8 + x^6 + x^5 + x^4, one step per bit taken
    function automatic int randBits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
            lfsr  = {lfsr[6:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // highest count, lowest bin on a tie, empty gives bin 0
    function automatic sifhBusPkg::peakT expectedPeak(input int p);
        sifhBusPkg::peakT pk;
        pk.pixel = sifhCfgPkg::pixelT'(p);
        pk.bin   = '0;
        pk.count = '0;
        for (int b = 0; b < numBins; b++) begin
            if (refHist[p][b] > int'(pk.count)) begin
                pk.bin   = sifhCfgPkg::binT'(b);
                pk.count = sifhCfgPkg::countT'(refHist[p][b]);
            end
        end
        return pk;
    endfunction

    task automatic checkPeak(input string name, input sifhBusPkg::peakT got,
                             input sifhBusPkg::peakT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("** Error: %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic checkCount(input string name, input sifhCfgPkg::countT got,
                              input sifhCfgPkg::countT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("** Error: %s exp %h got %h", name, exp, got);
        end
    endtask

    // one event against one upstream credit
    task automatic sendEvent(input sifhCfgPkg::pixelT p, input sifhCfgPkg::binT b);
        int n;
        n = 0;
        while (sentCnt - retCnt >= queueDepth && n < creditLimit) begin
            eventValid = 1'b0;
            @(negedge clk);
            n++;
        end
        if (sentCnt - retCnt >= queueDepth) begin
            timeouts++;
            $display("timeout: no event credit came back in %0d cycles", creditLimit);
        end else begin
            eventValid    = 1'b1;
            eventIn.pixel = p;
            eventIn.bin   = b;
            sentCnt++;
            if (sentCnt - retCnt > maxOutstanding) begin
                maxOutstanding = sentCnt - retCnt;
            end
            // saturating like the counters
            if (refHist[p][b] < countMax) begin
                refHist[p][b]++;
            end
            @(negedge clk);
            eventValid = 1'b0;
        end
    endtask

    task automatic sendRandom(input int n);
        sifhCfgPkg::pixelT p;
        sifhCfgPkg::binT   b;
        for (int i = 0; i < n; i++) begin
            p = sifhCfgPkg::pixelT'(randBits(sifhCfgPkg::pixelBits));
            b = sifhCfgPkg::binT'(randBits(sifhCfgPkg::binBits));
            sendEvent(p, b);
        end
    endtask

    // all events built once every credit is back
    task automatic waitCreditsBack();
        int n;
        n = 0;
        while (retCnt != sentCnt && n < drainLimit) begin
            @(negedge clk);
            n++;
        end
        if (retCnt != sentCnt) begin
            timeouts++;
            $display("timeout: queue did not drain, %0d of %0d credits back", retCnt, sentCnt);
        end
    endtask

    task automatic waitBusy(input logic level);
        int n;
        n = 0;
        while (scanBusy !== level && n < scanLimit) begin
            @(negedge clk);
            n++;
        end
        if (scanBusy !== level) begin
            timeouts++;
            $display("timeout: scanBusy never went to %0d", level);
        end
    endtask

    task automatic pulseAcqDone();
        acqDone = 1'b1;
        @(negedge clk);
        acqDone = 1'b0;
    endtask

    // no credits returned, scan has to stall after peakCredits peaks
    task automatic holdCredits(input int base);
        int n;
        n = 0;
        peakCreditIn = 1'b0;
        while (peaksTotal - base < peakCredits && n < scanLimit) begin
            @(negedge clk);
            n++;
        end
        if (peaksTotal - base < peakCredits) begin
            timeouts++;
            $display("timeout: the first %0d peaks never arrived", peakCredits);
        end
        for (int i = 0; i < holdCycles; i++) begin
            @(negedge clk);
            if (peaksTotal - base > peakCredits) begin
                protocolErrors++;
                $display("peak sent with no output credit left");
            end
            if (scanBusy !== 1'b1) begin
                protocolErrors++;
                $display("scanBusy dropped while the scan was out of credits");
            end
        end
    endtask

    // return a credit per peak, after a random gap
    task automatic collectPeaks(input int base);
        int n;
        int gap;
        n   = 0;
        gap = randBits(2);
        while ((peaksTotal - base < numPixels || creditsGiven < peaksTotal)
               && n < scanLimit) begin
            peakCreditIn = 1'b0;
            if (creditsGiven < peaksTotal) begin
                if (gap == 0) begin
                    peakCreditIn = 1'b1;
                    creditsGiven++;
                    gap = randBits(2);
                end else begin
                    gap--;
                end
            end
            @(negedge clk);
            n++;
        end
        peakCreditIn = 1'b0;
        if (peaksTotal - base < numPixels) begin
            timeouts++;
            $display("timeout: only %0d peaks after acqDone", peaksTotal - base);
        end
    endtask

    task automatic checkScan(input int acq);
        sifhBusPkg::peakT got;
        if (peakQ.size() != numPixels) begin
            protocolErrors++;
            $display("acquisition %0d gave %0d peaks, not %0d", acq, peakQ.size(), numPixels);
        end
        for (int p = 0; p < numPixels && peakQ.size() > 0; p++) begin
            got = peakQ.pop_front();
            checkPeak("peakOut", got, expPeaks[p]);
            if (acq == 0 && p == 0) begin
                // 300 events into one bin
                checkCount("peakOut.count", got.count, sifhCfgPkg::countT'(countMax));
            end
        end
        peakQ.delete();
    endtask

    // outputs sampled on the rising edge
    always @(posedge clk) begin
        if (arstN) begin
            if (eventCredit) begin
                retCnt++;
                if (retCnt > sentCnt) begin
                    protocolErrors++;
                    $display("eventCredit pulse with no event outstanding");
                end
            end
            if (peakValid) begin
                peakQ.push_back(peakOut);
                peaksTotal++;
            end
        end
    end

    initial begin
        int rowIdx;
        int n;
        int base;
        int assertFails;
        eventValid   = 1'b0;
        eventIn      = '0;
        acqDone      = 1'b0;
        peakCreditIn = 1'b0;
        rowIdx       = 0;
        n            = 0;
        foreach (refHist[i, j]) begin
            refHist[i][j] = 0;
        end
        while (arstN !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (arstN !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
        for (int acq = 0; acq < numAcqs; acq++) begin
            while (rowIdx < numRows && int'(stimTable[rowIdx].acq) == acq) begin
                for (int r = 0; r < int'(stimTable[rowIdx].reps); r++) begin
                    sendEvent(stimTable[rowIdx].pixel, stimTable[rowIdx].bin);
                end
                rowIdx++;
            end
            waitCreditsBack();
            // freeze this acquisition, model restarts empty
            for (int p = 0; p < numPixels; p++) begin
                expPeaks[p] = expectedPeak(p);
            end
            foreach (refHist[i, j]) begin
                refHist[i][j] = 0;
            end
            base = peaksTotal;
            pulseAcqDone();
            waitBusy(1'b1);
            if (acq == 0) begin
                // next acquisition, parked in the queue during the scan
                sendRandom(queueDepth);
            end
            if (acq == holdAcq) begin
                holdCredits(base);
            end
            collectPeaks(base);
            waitBusy(1'b0);
            checkScan(acq);
            if (acq == 0) begin
                sendRandom(randEvents - queueDepth);
            end
        end
        if (retCnt != sentCnt) begin
            protocolErrors++;
            $display("%0d eventCredit pulses for %0d events sent", retCnt, sentCnt);
        end
        // the long burst outruns the builder, so all credits must have been in use
        if (maxOutstanding != queueDepth) begin
            protocolErrors++;
            $display("at most %0d events outstanding, credits never ran out at the queue depth",
                     maxOutstanding);
        end
        assertFails = sifhTop_inst.sifhTopChk_inst.failCount;
        $display("errors: value %0d, protocol %0d, timeout %0d, assertion %0d",
                 valueErrors, protocolErrors, timeouts, assertFails);
        if (valueErrors + protocolErrors + timeouts + assertFails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sifhHist.f ====
verilog/sifhCfgPkg.sv
verilog/sifhBusPkg.sv
verilog/eventQueue.sv
verilog/histBuilder.sv
verilog/peakScanner.sv
verilog/memArbiter.sv
verilog/histRam.sv
verilog/sifhTop.sv
tests/sifhClkGen.sv
tests/sifhTop_chk.sv
tests/sifhTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= sifhHist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
SIMARGS   ?= +verilator+error+limit+100
PASSMSG   ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)
